//--- design/exu_pkg.sv
`default_nettype none

package exu_pkg;

  // fixed RV64 datapath
  localparam int XLEN      = 64;
  localparam int REG_IDX_W = 5;

  // execute unit selector
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_BJP = 2'd1,
    UNIT_LS  = 2'd2
  } exu_unit_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    BJP_JAL  = 3'd0,
    BJP_JALR = 3'd1,
    BJP_BEQ  = 3'd2,
    BJP_BNE  = 3'd3,
    BJP_BLT  = 3'd4,
    BJP_BGE  = 3'd5,
    BJP_BLTU = 3'd6,
    BJP_BGEU = 3'd7
  } bjp_op_e;

  // access size in bytes is 1 << size
  typedef enum logic [1:0] {
    LS_BYTE   = 2'd0,
    LS_HALF   = 2'd1,
    LS_WORD   = 2'd2,
    LS_DOUBLE = 2'd3
  } ls_size_e;

  typedef struct packed {
    logic     load;
    logic     store;
    logic     usign;
    ls_size_e size;
  } ls_info_t;

  // decoded instruction as handed over by issue
  typedef struct packed {
    exu_unit_e             unit;
    alu_op_e               alu_op;
    bjp_op_e               bjp_op;
    logic                  wop;
    ls_info_t              ls_info;
    logic                  rd_wr_en;
    logic [REG_IDX_W-1:0]  rd_idx;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       op1_jp;
    logic [XLEN-1:0]       op2_jp_s;
  } issue_t;

  typedef struct packed {
    logic                  rd_wr_en;
    logic [REG_IDX_W-1:0]  rd_idx;
    logic [XLEN-1:0]       alu_res;
    ls_info_t              ls_info;
    logic [XLEN-1:0]       rs2_store;
    logic                  jump_flag;
    logic [XLEN-1:0]       jump_addr;
  } result_t;

endpackage

`default_nettype wire

//--- design/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     rst_n_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  input  wire payload_t data_i,
  output logic          valid_o,
  input  wire logic     ready_i,
  output payload_t      data_o
);

  logic load_en;

  // accept when empty or when the held entry leaves this cycle
  assign ready_o = ~valid_o | ready_i;
  assign load_en = valid_i & ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk) begin
    if (load_en) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
  input  wire logic [exu_pkg::XLEN-1:0] op1_i,
  input  wire logic [exu_pkg::XLEN-1:0] op2_i,
  input  wire exu_pkg::alu_op_e         alu_op_i,
  input  wire logic                     wop_i,
  input  wire logic                     force_add_i,
  input  wire logic                     force_sub_i,
  output logic [exu_pkg::XLEN-1:0]      res_o,
  output logic                          lt_o,
  output logic                          ltu_o,
  output logic                          eq_o
);

  import exu_pkg::*;

  alu_op_e         eff_op;
  logic            sub_sel;
  logic [XLEN-1:0] adder_in2;
  logic [XLEN-1:0] adder_res;
  logic            adder_cout;
  logic [5:0]      shamt;
  logic [4:0]      shamt_w;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [31:0]     sllw_res;
  logic [31:0]     srlw_res;
  logic [31:0]     sraw_res;

  function automatic logic [XLEN-1:0] sext_w(input logic [31:0] val);
    return {{(XLEN-32){val[31]}}, val};
  endfunction

  // link value and address generation override the decoded op
  always_comb begin
    if (force_add_i) begin
      eff_op = ALU_ADD;
    end else if (force_sub_i) begin
      eff_op = ALU_SUB;
    end else begin
      eff_op = alu_op_i;
    end
  end

  assign sub_sel = (eff_op == ALU_SUB) | (eff_op == ALU_SLT) | (eff_op == ALU_SLTU);

  // single adder that subtracts as op1 + ~op2 + 1
  assign adder_in2 = sub_sel ? ~op2_i : op2_i;
  assign {adder_cout, adder_res} = {1'b0, op1_i} + {1'b0, adder_in2} + {{XLEN{1'b0}}, sub_sel};

  // compares only meaningful while subtracting
  assign ltu_o = ~adder_cout;
  assign lt_o  = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                 (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & adder_res[XLEN-1]);
  assign eq_o  = ~|adder_res;

  assign shamt   = op2_i[5:0];
  assign shamt_w = op2_i[4:0];

  assign sll_res = op1_i << shamt;
  assign srl_res = op1_i >> shamt;
  assign sra_res = $signed(op1_i) >>> shamt;

  // word shifts work on the low half only
  assign sllw_res = op1_i[31:0] << shamt_w;
  assign srlw_res = op1_i[31:0] >> shamt_w;
  assign sraw_res = $signed(op1_i[31:0]) >>> shamt_w;

  always_comb begin
    case (eff_op)
      ALU_ADD, ALU_SUB: res_o = wop_i ? sext_w(adder_res[31:0]) : adder_res;
      ALU_SLL:          res_o = wop_i ? sext_w(sllw_res) : sll_res;
      ALU_SRL:          res_o = wop_i ? sext_w(srlw_res) : srl_res;
      ALU_SRA:          res_o = wop_i ? sext_w(sraw_res) : sra_res;
      ALU_SLT:          res_o = {{(XLEN-1){1'b0}}, lt_o};
      ALU_SLTU:         res_o = {{(XLEN-1){1'b0}}, ltu_o};
      ALU_XOR:          res_o = op1_i ^ op2_i;
      ALU_OR:           res_o = op1_i | op2_i;
      ALU_AND:          res_o = op1_i & op2_i;
      // upper immediate arrives already shifted in op2
      ALU_LUI:          res_o = op2_i;
      default:          res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
  input  wire exu_pkg::bjp_op_e         bjp_op_i,
  input  wire logic                     active_i,
  input  wire logic                     lt_i,
  input  wire logic                     ltu_i,
  input  wire logic                     eq_i,
  input  wire logic [exu_pkg::XLEN-1:0] op1_jp_i,
  input  wire logic [exu_pkg::XLEN-1:0] op2_jp_s_i,
  output logic                          jump_flag_o,
  output logic [exu_pkg::XLEN-1:0]      jump_addr_o
);

  import exu_pkg::*;

  logic taken;

  // compare results come from the ALU subtract
  always_comb begin
    case (bjp_op_i)
      BJP_JAL,
      BJP_JALR: taken = 1'b1;
      BJP_BEQ:  taken = eq_i;
      BJP_BNE:  taken = ~eq_i;
      BJP_BLT:  taken = lt_i;
      BJP_BGE:  taken = ~lt_i;
      BJP_BLTU: taken = ltu_i;
      BJP_BGEU: taken = ~ltu_i;
      default:  taken = 1'b0;
    endcase
  end

  assign jump_flag_o = active_i & taken;

  // decode picks pc or rs1 as the base for the offset
  assign jump_addr_o = op1_jp_i + op2_jp_s_i;

endmodule

`default_nettype wire

//--- design/exu_stage.sv
`timescale 1ns/100ps
`default_nettype none

module exu_stage (
  input  wire exu_pkg::issue_t issue_i,
  output exu_pkg::result_t     result_o
);

  import exu_pkg::*;

  logic            alu_req;
  logic            bjp_req;
  logic            ls_req;
  logic            is_jump;
  logic            force_add;
  logic            force_sub;
  logic            alu_wop;
  logic [XLEN-1:0] alu_res;
  logic            cmp_lt;
  logic            cmp_ltu;
  logic            cmp_eq;
  logic            jump_flag;
  logic [XLEN-1:0] jump_addr;

  // unit decode
  assign alu_req = (issue_i.unit == UNIT_ALU);
  assign bjp_req = (issue_i.unit == UNIT_BJP);
  assign ls_req  = (issue_i.unit == UNIT_LS);

  assign is_jump = bjp_req & ((issue_i.bjp_op == BJP_JAL) | (issue_i.bjp_op == BJP_JALR));

  // jal/jalr add op1 and op2 for the link value
  assign force_add = ls_req | is_jump;
  // conditional branches need the compare flags
  assign force_sub = bjp_req & ~is_jump;
  assign alu_wop   = alu_req & issue_i.wop;

  alu_unit i_alu_unit (
    .op1_i       (issue_i.op1),
    .op2_i       (issue_i.op2),
    .alu_op_i    (issue_i.alu_op),
    .wop_i       (alu_wop),
    .force_add_i (force_add),
    .force_sub_i (force_sub),
    .res_o       (alu_res),
    .lt_o        (cmp_lt),
    .ltu_o       (cmp_ltu),
    .eq_o        (cmp_eq)
  );

  branch_unit i_branch_unit (
    .bjp_op_i    (issue_i.bjp_op),
    .active_i    (bjp_req),
    .lt_i        (cmp_lt),
    .ltu_i       (cmp_ltu),
    .eq_i        (cmp_eq),
    .op1_jp_i    (issue_i.op1_jp),
    .op2_jp_s_i  (issue_i.op2_jp_s),
    .jump_flag_o (jump_flag),
    .jump_addr_o (jump_addr)
  );

  always_comb begin
    result_o.rd_wr_en  = issue_i.rd_wr_en;
    result_o.rd_idx    = issue_i.rd_idx;
    // effective address for loads and stores
    result_o.alu_res   = alu_res;
    result_o.ls_info   = ls_req ? issue_i.ls_info : '0;
    result_o.rs2_store = (ls_req & issue_i.ls_info.store) ? issue_i.op2_jp_s : '0;
    result_o.jump_flag = jump_flag;
    result_o.jump_addr = jump_addr;
  end

endmodule

`default_nettype wire

//--- design/exu_top.sv
`timescale 1ns/100ps
`default_nettype none

module exu_top (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic            in_valid_i,
  output logic                 in_ready_o,
  input  wire exu_pkg::issue_t in_data_i,
  output logic                 out_valid_o,
  input  wire logic            out_ready_i,
  output exu_pkg::result_t     out_data_o
);

  import exu_pkg::*;

  logic    issue_valid;
  logic    result_ready;
  issue_t  issue_q;
  result_t stage_result;

  // issue register
  pipe_reg #(
    .payload_t (issue_t)
  ) i_issue_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_data_i),
    .valid_o (issue_valid),
    .ready_i (result_ready),
    .data_o  (issue_q)
  );

  exu_stage i_exu_stage (
    .issue_i  (issue_q),
    .result_o (stage_result)
  );

  // result register holds until the consumer takes it
  pipe_reg #(
    .payload_t (result_t)
  ) i_result_reg (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (issue_valid),
    .ready_o (result_ready),
    .data_i  (stage_result),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data_o)
  );

endmodule

`default_nettype wire

//--- test/exu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module exu_checker (
  input  wire logic             clk,
  input  wire logic             rst_n_i,
  input  wire logic             in_valid_i,
  input  wire logic             in_ready_i,
  input  wire exu_pkg::issue_t  in_data_i,
  input  wire logic             out_valid_i,
  input  wire logic             out_ready_i,
  input  wire exu_pkg::result_t out_data_i,
  input  wire logic             lat_check_i,
  output int                    in_cnt_o,
  output int                    out_cnt_o,
  output int                    err_cnt_o
);

  import exu_pkg::*;

  result_t exp_q[$];
  issue_t  iss_q[$];
  int      stamp_q[$];
  int      cycle;
  result_t exp_e;
  issue_t  iss_e;
  int      lat;

  function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic string test_name(input issue_t it);
    case (it.unit)
      UNIT_ALU: return $sformatf("alu op %0d wop %0d", it.alu_op, it.wop);
      UNIT_BJP: return $sformatf("branch op %0d", it.bjp_op);
      default:  return "load/store";
    endcase
  endfunction

  // expected result from the ISA rules
  function automatic result_t ref_result(input issue_t it);
    result_t         r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    r = '0;
    a = it.op1;
    b = it.op2;
    r.rd_wr_en  = it.rd_wr_en;
    r.rd_idx    = it.rd_idx;
    r.jump_addr = it.op1_jp + it.op2_jp_s;
    case (it.unit)
      UNIT_ALU: begin
        case (it.alu_op)
          ALU_ADD:  r.alu_res = it.wop ? sext32(a[31:0] + b[31:0]) : a + b;
          ALU_SUB:  r.alu_res = it.wop ? sext32(a[31:0] - b[31:0]) : a - b;
          ALU_SLL:  r.alu_res = it.wop ? sext32(a[31:0] << b[4:0]) : a << b[5:0];
          ALU_SRL:  r.alu_res = it.wop ? sext32(a[31:0] >> b[4:0]) : a >> b[5:0];
          // word form shifts the sign-extended low half
          ALU_SRA:  r.alu_res = it.wop ? $signed(sext32(a[31:0])) >>> b[4:0]
                                       : $signed(a) >>> b[5:0];
          ALU_SLT:  r.alu_res = {63'b0, $signed(a) < $signed(b)};
          ALU_SLTU: r.alu_res = {63'b0, a < b};
          ALU_XOR:  r.alu_res = a ^ b;
          ALU_OR:   r.alu_res = a | b;
          ALU_AND:  r.alu_res = a & b;
          ALU_LUI:  r.alu_res = b;
          default:  r.alu_res = '0;
        endcase
      end
      UNIT_BJP: begin
        case (it.bjp_op)
          BJP_JAL, BJP_JALR: r.jump_flag = 1'b1;
          BJP_BEQ:  r.jump_flag = (a == b);
          BJP_BNE:  r.jump_flag = (a != b);
          BJP_BLT:  r.jump_flag = ($signed(a) < $signed(b));
          BJP_BGE:  r.jump_flag = ($signed(a) >= $signed(b));
          BJP_BLTU: r.jump_flag = (a < b);
          BJP_BGEU: r.jump_flag = (a >= b);
          default:  r.jump_flag = 1'b0;
        endcase
        // link value for jumps, difference for branches
        r.alu_res = (it.bjp_op == BJP_JAL || it.bjp_op == BJP_JALR) ? a + b : a - b;
      end
      UNIT_LS: begin
        r.alu_res   = a + b;
        r.ls_info   = it.ls_info;
        r.rs2_store = it.ls_info.store ? it.op2_jp_s : '0;
      end
      default: r.alu_res = '0;
    endcase
    return r;
  endfunction

  initial begin
    in_cnt_o  = 0;
    out_cnt_o = 0;
    err_cnt_o = 0;
    cycle     = 0;
  end

  always @(posedge clk) begin
    if (!rst_n_i) begin
      cycle = 0;
    end else begin
      cycle++;
      if (in_valid_i && in_ready_i) begin
        exp_q.push_back(ref_result(in_data_i));
        iss_q.push_back(in_data_i);
        stamp_q.push_back(cycle);
        in_cnt_o++;
      end
      if (out_valid_i && out_ready_i) begin
        out_cnt_o++;
        if (exp_q.size() == 0) begin
          $display("Error: a result came out with no instruction outstanding");
          err_cnt_o++;
        end else begin
          exp_e = exp_q.pop_front();
          iss_e = iss_q.pop_front();
          lat   = cycle - stamp_q.pop_front();
          if (out_data_i !== exp_e) begin
            $display("Error %s: expected %h actual %h", test_name(iss_e), exp_e, out_data_i);
            err_cnt_o++;
          end
          if (lat_check_i && lat != 2) begin
            $display("Error latency %s: expected 2 actual %0d", test_name(iss_e), lat);
            err_cnt_o++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/exu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exu_tb;

  import exu_pkg::*;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        rst_n_i;
  logic        in_valid_i;
  logic        in_ready_o;
  issue_t      in_data_i;
  logic        out_valid_o;
  logic        out_ready_i;
  result_t     out_data_o;
  logic        lat_check;
  logic        ready_random;
  logic [31:0] seed;
  logic [31:0] ready_seed;
  int          in_cnt;
  int          out_cnt;
  int          chk_errors;
  int          tb_errors;

  exu_top i_exu_top (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  exu_checker i_exu_checker (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_i  (out_data_o),
    .lat_check_i (lat_check),
    .in_cnt_o    (in_cnt),
    .out_cnt_o   (out_cnt),
    .err_cnt_o   (chk_errors)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // edge operands with bit 31 cases for the word forms
  function automatic logic [XLEN-1:0] edge_value(input int idx);
    case (idx)
      0:       return 64'h0;
      1:       return '1;
      2:       return 64'h8000_0000_0000_0000;
      3:       return 64'd31;
      4:       return 64'd32;
      5:       return 64'd63;
      6:       return 64'h7fff_ffff_ffff_ffff;
      default: return 64'h0000_0000_8000_0000;
    endcase
  endfunction

  function automatic logic has_word(input logic [3:0] op);
    return op == ALU_ADD || op == ALU_SUB || op == ALU_SLL || op == ALU_SRL || op == ALU_SRA;
  endfunction

  task automatic finish_run();
    int errors;
    errors = tb_errors + chk_errors;
    $display("issued %0d, received %0d, errors %0d", in_cnt, out_cnt, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic rand_word(output logic [XLEN-1:0] v);
    seed = lcg_next(seed);
    v[63:32] = seed;
    seed = lcg_next(seed);
    v[31:0] = seed;
    // about one in four is an edge value
    if (seed[31:30] == 2'b00) begin
      v = edge_value(seed[29:27]);
    end
  endtask

  // fields the unit ignores stay random
  task automatic rand_issue(output issue_t it);
    logic [287:0] raw;
    for (int i = 0; i < 9; i++) begin
      seed = lcg_next(seed);
      raw[i*32 +: 32] = seed;
    end
    it = raw[$bits(issue_t)-1:0];
  endtask

  task automatic send(input issue_t it);
    int   waited;
    logic rdy;
    waited = 0;
    rdy = 1'b0;
    in_valid_i = 1'b1;
    in_data_i = it;
    while (!rdy) begin
      @(negedge clk);
      rdy = in_ready_o;
      @(posedge clk);
      #2;
      waited++;
      if (!rdy && waited >= TIMEOUT) begin
        $display("timeout: the DUT never accepted an instruction");
        tb_errors++;
        finish_run();
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_op(input exu_unit_e unit, input logic [3:0] op, input logic w,
                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    issue_t it;
    rand_issue(it);
    it.unit = unit;
    if (unit == UNIT_ALU) begin
      it.alu_op = alu_op_e'(op);
      it.wop = w;
    end else if (unit == UNIT_BJP) begin
      it.bjp_op = bjp_op_e'(op[2:0]);
    end
    it.op1 = a;
    it.op2 = b;
    send(it);
  endtask

  task automatic edge_sweep(input exu_unit_e unit, input int nops);
    for (int op = 0; op < nops; op++) begin
      for (int w = 0; w < 2; w++) begin
        if (w == 0 || (unit == UNIT_ALU && has_word(op))) begin
          for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
              send_op(unit, op, w, edge_value(i), edge_value(j));
            end
          end
        end
      end
    end
  endtask

  task automatic random_run(input exu_unit_e unit, input int nops, input int count);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [3:0]      op;
    for (int n = 0; n < count; n++) begin
      rand_word(a);
      rand_word(b);
      seed = lcg_next(seed);
      op = seed[27:24] % nops;
      // equal operands now and then for beq/bge
      if (seed[3:2] == 2'b00) begin
        b = a;
      end
      send_op(unit, op, seed[8] & has_word(op), a, b);
      if (seed[12]) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (in_cnt != out_cnt) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited >= TIMEOUT) begin
        $display("timeout: %0d results never came out", in_cnt - out_cnt);
        tb_errors++;
        finish_run();
      end
    end
  endtask

  // consumer back-pressure
  always @(posedge clk) begin
    #2;
    if (ready_random) begin
      ready_seed = lcg_next(ready_seed);
      out_ready_i = ready_seed[19];
    end else begin
      out_ready_i = 1'b1;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n_i = 1'b0;
    in_valid_i = 1'b0;
    in_data_i = '0;
    out_ready_i = 1'b0;
    lat_check = 1'b0;
    ready_random = 1'b1;
    seed = 32'he28b;
    ready_seed = 32'he28b;
    tb_errors = 0;
    repeat (4) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk);
    if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("Error reset: expected valid 0 ready 1 actual valid %b ready %b",
               out_valid_o, in_ready_o);
      tb_errors++;
    end
    @(posedge clk);
    #2;
    edge_sweep(UNIT_ALU, 11);
    random_run(UNIT_ALU, 11, 300);
    edge_sweep(UNIT_BJP, 8);
    random_run(UNIT_BJP, 8, 200);
    edge_sweep(UNIT_LS, 1);
    random_run(UNIT_LS, 1, 150);
    drain();
    // consumer always ready so the latency is fixed
    ready_random = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    lat_check = 1'b1;
    random_run(UNIT_ALU, 11, 40);
    random_run(UNIT_BJP, 8, 30);
    random_run(UNIT_LS, 1, 30);
    drain();
    lat_check = 1'b0;
    finish_run();
  end

endmodule

`default_nettype wire

//--- flist.f
design/exu_pkg.sv
design/pipe_reg.sv
design/alu_unit.sv
design/branch_unit.sv
design/exu_stage.sv
design/exu_top.sv
test/exu_checker.sv
test/exu_tb.sv
